// File: flist.f
verilog/m1_pkg.sv
verilog/data_addr_map.sv
verilog/cp0_regs.sv
verilog/m1_stage.sv
verification/m1_tb_clk.sv
verification/m1_stage_props.sv
verification/m1_stage_tb.sv

// File: Bender.yml
package:
  name: m1_stage

sources:
  - files:
      - verilog/m1_pkg.sv
      - verilog/data_addr_map.sv
      - verilog/cp0_regs.sv
      - verilog/m1_stage.sv
  - target: simulation
    files:
      - verification/m1_tb_clk.sv
      - verification/m1_stage_props.sv
      - verification/m1_stage_tb.sv

// File: verification/m1_stage_tb.sv
`timescale 1ns/1ps

module m1_stage_tb import m1_pkg::*; ();

    logic        clk;
    logic        reset;
    logic [5:0]  ext_int;
    logic        es_to_m1s_valid;
    es_to_m1_t   es_to_m1s_bus;
    logic        m1s_allowin;
    logic        ms_allowin;
    logic        m1s_to_ms_valid;
    m1_to_ms_t   m1s_to_ms_bus;
    logic        data_valid;
    dcache_req_t data_req;
    logic        data_addr_ok;
    logic        data_data_ok = 1'b0;
    logic        isUncache;
    logic        flush;
    logic [31:0] exception_pc;
    logic [4:0]  fwd_dest;
    logic [31:0] fwd_result;
    logic        fwd_load;
    logic        fwd_mfc0;
    logic        status_exl;

    // stage output snapshot in its fire cycle
    m1_to_ms_t   out_bus;
    logic        out_flush;
    logic [4:0]  out_fwd_dest;
    logic [31:0] out_fwd_result;
    logic        out_fwd_load;
    logic        out_fwd_mfc0;
    logic        out_data_ok;
    logic [31:0] out_epc;

    // cache model state
    logic        accept_seen;
    dcache_req_t seen_req;
    logic        seen_uncache;
    logic [2:0]  wait_cnt = 3'd0;
    int          req_count = 0;
    int          ok_count = 0;
    logic [31:0] lat_state = 32'd21;

    logic [31:0] rng_state = 32'd21;
    int          cycle_count = 0;
    // bumped by the bound assertions
    int          prop_fail_count = 0;

    m1_tb_clk u_clk (
        .clk   (clk),
        .reset (reset)
    );

    m1_stage i_dut (.*);

    bind m1_stage m1_stage_props i_props (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .data_valid      (data_valid),
        .m1s_to_ms_valid (m1s_to_ms_valid),
        .ms_allowin      (ms_allowin),
        .m1s_to_ms_bus   (m1s_to_ms_bus)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
    end

    // first bound assertion failure ends the run
    always @(prop_fail_count) begin
        if (prop_fail_count != 0) begin
            fail_plain("bound assertion on the stage handshake or flush failed");
        end
    end

    // cache model with addr_ok always high and data_ok 1 to 4 cycles after acceptance
    always begin
        @(negedge clk);
        accept_seen = data_valid && data_addr_ok;
        if (accept_seen) begin
            seen_req     = data_req;
            seen_uncache = isUncache;
            req_count    = req_count + 1;
        end
        @(posedge clk);
        #2;
        data_data_ok = 1'b0;
        if (reset) begin
            wait_cnt = 3'd0;
        end else begin
            if (wait_cnt != 3'd0) begin
                wait_cnt = wait_cnt - 3'd1;
                if (wait_cnt == 3'd0) begin
                    data_data_ok = 1'b1;
                    ok_count     = ok_count + 1;
                end
            end
            if (accept_seen) begin
                lat_state = xorshift32(lat_state);
                wait_cnt  = 3'd1 + {1'b0, lat_state[1:0]};
            end
        end
    end

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        stop_on_error();
    endtask

    function automatic es_to_m1_t blank_word(input logic [31:0] pc);
        es_to_m1_t w;
        w    = '0;
        w.pc = pc;
        return w;
    endfunction

    // offer a word at edge+2 until the stage takes it
    task automatic send_word(input es_to_m1_t w);
        int cycles;
        cycles          = 0;
        es_to_m1s_bus   = w;
        es_to_m1s_valid = 1'b1;
        @(negedge clk);
        while (!m1s_allowin) begin
            if (cycles == 50) begin
                fail_plain("timeout: stage never accepted the word");
            end else begin
                cycles = cycles + 1;
                @(negedge clk);
            end
        end
        @(posedge clk);
        #2;
        es_to_m1s_valid = 1'b0;
    endtask

    // sampled mid-cycle away from the edges
    task automatic wait_output();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(m1s_to_ms_valid && ms_allowin)) begin
            if (cycles == 50) begin
                fail_plain("timeout: no word handed to memory-2");
            end else begin
                cycles = cycles + 1;
                @(negedge clk);
            end
        end
        out_bus        = m1s_to_ms_bus;
        out_flush      = flush;
        out_fwd_dest   = fwd_dest;
        out_fwd_result = fwd_result;
        out_fwd_load   = fwd_load;
        out_fwd_mfc0   = fwd_mfc0;
        out_data_ok    = data_data_ok;
        out_epc        = exception_pc;
        @(posedge clk);
        #2;
    endtask

    task automatic write_cp0(input logic [4:0] num, input logic [31:0] value);
        es_to_m1_t w;
        w            = blank_word(32'hbfc0_1000);
        w.inst_mtc0  = 1'b1;
        w.cp0_addr   = num;
        w.alu_result = value;
        send_word(w);
        wait_output();
        check_value("mtc0 ex", out_bus.ex, 1'b0);
    endtask

    task automatic read_cp0(input logic [4:0] num, output logic [31:0] value);
        es_to_m1_t w;
        w           = blank_word(32'hbfc0_1004);
        w.inst_mfc0 = 1'b1;
        w.cp0_addr  = num;
        w.gr_we     = 1'b1;
        w.dest      = 5'd2;
        send_word(w);
        wait_output();
        check_value("mfc0 ex", out_bus.ex, 1'b0);
        check_value("fwd_mfc0", out_fwd_mfc0, 1'b1);
        check_value("fwd_dest", out_fwd_dest, 5'd2);
        value = out_bus.result;
    endtask

    task automatic take_eret(output logic [31:0] epc_seen);
        es_to_m1_t w;
        w           = blank_word(32'hbfc0_0400);
        w.inst_eret = 1'b1;
        send_word(w);
        wait_output();
        check_value("flush on eret", out_flush, 1'b1);
        check_value("eret ex", out_bus.ex, 1'b0);
        check_value("status_exl", status_exl, 1'b0);
        epc_seen = out_epc;
    endtask

    task automatic reset_check();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (reset) begin
            if (cycles == 10) begin
                fail_plain("reset never released");
            end else begin
                cycles = cycles + 1;
                @(negedge clk);
            end
        end
        check_value("m1s_to_ms_valid", m1s_to_ms_valid, 1'b0);
        check_value("data_valid", data_valid, 1'b0);
        check_value("flush", flush, 1'b0);
        check_value("fwd_dest", fwd_dest, 5'd0);
        check_value("status_exl", status_exl, 1'b0);
        @(posedge clk);
        #2;
    endtask

    task automatic alu_pass_test();
        es_to_m1_t   w;
        logic [31:0] r;
        for (int i = 0; i < 8; i++) begin
            r            = rand32();
            w            = blank_word(rand32() & 32'hffff_fffc);
            w.alu_result = rand32();
            w.dest       = r[4:0];
            w.gr_we      = r[5];
            send_word(w);
            wait_output();
            check_value("pc", out_bus.pc, w.pc);
            check_value("result", out_bus.result, w.alu_result);
            check_value("fwd_result", out_fwd_result, w.alu_result);
            check_value("dest", out_bus.dest, w.dest);
            check_value("gr_we", out_bus.gr_we, w.gr_we);
            check_value("ex", out_bus.ex, 1'b0);
            check_value("flush", out_flush, 1'b0);
            check_value("fwd_dest", out_fwd_dest, w.gr_we ? w.dest : 5'd0);
        end
        // word must sit still while memory-2 stalls
        w            = blank_word(32'h0040_1000);
        w.alu_result = rand32();
        w.dest       = 5'd9;
        w.gr_we      = 1'b1;
        ms_allowin   = 1'b0;
        send_word(w);
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            check_value("m1s_to_ms_valid", m1s_to_ms_valid, 1'b1);
            check_value("m1s_allowin", m1s_allowin, 1'b0);
            check_value("fwd_dest", fwd_dest, 5'd9);
            check_value("result", m1s_to_ms_bus.result, w.alu_result);
        end
        @(posedge clk);
        #2;
        ms_allowin = 1'b1;
        wait_output();
        check_value("pc", out_bus.pc, w.pc);
    endtask

    task automatic mem_access_test();
        es_to_m1_t   w;
        logic [2:0]  segs [4];
        logic [31:0] r;
        logic [31:0] va;
        logic [31:0] exp_pa;
        logic        st;
        int          reqs;
        int          oks;
        // kseg0, kseg1, kuseg, kseg2
        segs[0] = 3'b100;
        segs[1] = 3'b101;
        segs[2] = 3'b000;
        segs[3] = 3'b110;
        for (int s = 0; s < 4; s++) begin
            for (int j = 0; j < 2; j++) begin
                st = (j == 1);
                r  = rand32();
                // word load, or byte store on a random lane
                va = {segs[s], r[28:2], st ? r[31:30] : 2'b00};
                // kseg0 and kseg1 land in the low 512 MB
                exp_pa = (s < 2) ? (va & 32'h1fff_ffff) : va;
                w            = blank_word(32'h0040_2000 + 32'(8 * s + 4 * j));
                w.alu_result = va;
                w.mem_size   = st ? size_byte : size_word;
                w.load_op    = !st;
                w.mem_we     = st;
                w.gr_we      = !st;
                w.dest       = 5'd4;
                w.mem_wstrb  = st ? (4'b0001 << va[1:0]) : 4'b0000;
                w.mem_wdata  = rand32();
                reqs = req_count;
                oks  = ok_count;
                send_word(w);
                wait_output();
                check_value("accepted requests", req_count - reqs, 1);
                check_value("data_ok count", ok_count - oks, 1);
                check_value("data_data_ok at output", out_data_ok, 1'b1);
                check_value("data_req address",
                            {seen_req.tag, seen_req.index, seen_req.offset}, exp_pa);
                check_value("isUncache", seen_uncache, s == 1);
                check_value("data_req.op", seen_req.op, st);
                check_value("data_req.wstrb", seen_req.wstrb, w.mem_wstrb);
                check_value("data_req.wdata", seen_req.wdata, w.mem_wdata);
                check_value("pc", out_bus.pc, w.pc);
                check_value("load_op", out_bus.load_op, !st);
                check_value("fwd_load", out_fwd_load, !st);
                check_value("mem_size", out_bus.mem_size, w.mem_size);
                check_value("addr_low", out_bus.addr_low, va[1:0]);
                check_value("ex", out_bus.ex, 1'b0);
            end
        end
    endtask

    task automatic misaligned_case(input logic [31:0] pc, input logic [31:0] addr,
                                   input logic [1:0] size, input logic st,
                                   input logic bd);
        es_to_m1_t   w;
        logic [31:0] v;
        int          reqs;
        w            = blank_word(pc);
        w.alu_result = addr;
        w.mem_size   = size;
        w.load_op    = !st;
        w.mem_we     = st;
        w.gr_we      = !st;
        w.bd         = bd;
        reqs = req_count;
        send_word(w);
        wait_output();
        check_value("ex", out_bus.ex, 1'b1);
        check_value("flush", out_flush, 1'b1);
        check_value("accepted requests", req_count - reqs, 0);
        check_value("status_exl", status_exl, 1'b1);
        read_cp0(cp0_cause, v);
        check_value("cause.exccode", v[6:2], st ? exc_ades : exc_adel);
        check_value("cause.bd", v[31], bd);
        read_cp0(cp0_badvaddr, v);
        check_value("badvaddr", v, addr);
        check_value("fwd_result", out_fwd_result, addr);
        read_cp0(cp0_epc, v);
        check_value("epc", v, bd ? pc - 32'd4 : pc);
        // leave exception level so the next fault updates epc
        take_eret(v);
    endtask

    task automatic cp0_rw_test();
        logic [31:0] v;
        logic [31:0] epc_val;
        logic [31:0] st_val;
        read_cp0(cp0_status, v);
        check_value("status", v, 32'h0040_0000);
        epc_val = rand32() & 32'hffff_fffc;
        write_cp0(cp0_epc, epc_val);
        read_cp0(cp0_epc, v);
        check_value("epc", v, epc_val);
        check_value("fwd_result", out_fwd_result, epc_val);
        // junk in the read-only bits with exl set and ie clear
        st_val = (rand32() | 32'h2) & 32'hffff_fffe;
        write_cp0(cp0_status, st_val);
        read_cp0(cp0_status, v);
        check_value("status", v, 32'h0040_0000 | (st_val & 32'h0000_ff03));
        check_value("fwd_result", out_fwd_result, 32'h0040_0000 | (st_val & 32'h0000_ff03));
        check_value("status_exl", status_exl, 1'b1);
        take_eret(v);
        check_value("exception_pc", v, epc_val);
    endtask

    task automatic interrupt_test();
        es_to_m1_t   w;
        logic [31:0] v;
        logic [31:0] c;
        int          start;
        int          limit;
        logic        ti;
        // im2 and ie
        write_cp0(cp0_status, 32'h0000_0401);
        ext_int = 6'b000001;
        // one edge for cause.ip to sample the line
        @(posedge clk);
        #2;
        w            = blank_word(32'h0040_5000);
        w.alu_result = rand32();
        w.gr_we      = 1'b1;
        w.dest       = 5'd7;
        send_word(w);
        wait_output();
        check_value("ex on interrupt", out_bus.ex, 1'b1);
        check_value("flush", out_flush, 1'b1);
        check_value("status_exl", status_exl, 1'b1);
        ext_int = 6'b000000;
        read_cp0(cp0_cause, v);
        check_value("cause.exccode", v[6:2], exc_int);
        read_cp0(cp0_epc, v);
        check_value("epc", v, 32'h0040_5000);
        write_cp0(cp0_status, 32'h0000_0000);
        // timer with compare ten counts ahead
        read_cp0(cp0_count, c);
        start = cycle_count;
        write_cp0(cp0_compare, c + 32'd10);
        // two cycles per count plus one mfc0 round trip
        limit = 2 * 10 + 2 + 2;
        ti    = 1'b0;
        while (!ti) begin
            if (cycle_count - start > limit) begin
                fail_plain("timer interrupt not raised in time");
            end else begin
                read_cp0(cp0_cause, v);
                ti = v[30];
            end
        end
        check_value("cause.ip7", v[15], 1'b1);
        write_cp0(cp0_compare, c + 32'd1000);
        read_cp0(cp0_cause, v);
        check_value("cause.ti", v[30], 1'b0);
        check_value("cause.ip7", v[15], 1'b0);
    endtask

    initial begin
        ext_int         = 6'd0;
        es_to_m1s_valid = 1'b0;
        es_to_m1s_bus   = '0;
        ms_allowin      = 1'b1;
        data_addr_ok    = 1'b1;
        reset_check();
        alu_pass_test();
        mem_access_test();
        misaligned_case(32'h0040_3000, 32'h8000_1002, size_word, 1'b0, 1'b0);
        misaligned_case(32'h0040_3010, 32'ha000_2001, size_half, 1'b1, 1'b1);
        cp0_rw_test();
        interrupt_test();
        // let the last assertions evaluate
        repeat (2) @(posedge clk);
        if (prop_fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verification/m1_stage_props.sv
`timescale 1ns/1ps

module m1_stage_props import m1_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      flush,
    input logic      data_valid,
    input logic      m1s_to_ms_valid,
    input logic      ms_allowin,
    input m1_to_ms_t m1s_to_ms_bus
);

    // stage empties after a flush, so no second pulse
    flush_one_cycle: assert property (@(posedge clk) disable iff (reset)
        flush |=> !flush)
        else begin
            $error("flush high for more than one cycle");
            m1_stage_tb.prop_fail_count = m1_stage_tb.prop_fail_count + 1;
        end

    // faulting or eret words never talk to the cache
    no_req_on_flush: assert property (@(posedge clk) disable iff (reset)
        !(data_valid && flush))
        else begin
            $error("data_valid high together with flush");
            m1_stage_tb.prop_fail_count = m1_stage_tb.prop_fail_count + 1;
        end

    // back-pressure keeps the word and its content
    hold_stable: assert property (@(posedge clk) disable iff (reset)
        (m1s_to_ms_valid && !ms_allowin) |=> (m1s_to_ms_valid && $stable(m1s_to_ms_bus)))
        else begin
            $error("stage output changed under back-pressure");
            m1_stage_tb.prop_fail_count = m1_stage_tb.prop_fail_count + 1;
        end

endmodule

// File: verification/m1_tb_clk.sv
`timescale 1ns/1ps

module m1_tb_clk (
    output logic clk,
    output logic reset
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset over the first two rising edges, released just after the second
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

// File: verilog/m1_stage.sv
`timescale 1ns/1ps

module m1_stage import m1_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [5:0]  ext_int,
    input  logic        es_to_m1s_valid,
    input  es_to_m1_t   es_to_m1s_bus,
    output logic        m1s_allowin,
    input  logic        ms_allowin,
    output logic        m1s_to_ms_valid,
    output m1_to_ms_t   m1s_to_ms_bus,
    output logic        data_valid,
    output dcache_req_t data_req,
    input  logic        data_addr_ok,
    input  logic        data_data_ok,
    output logic        isUncache,
    output logic        flush,
    output logic [31:0] exception_pc,
    output logic [4:0]  fwd_dest,
    output logic [31:0] fwd_result,
    output logic        fwd_load,
    output logic        fwd_mfc0,
    output logic        status_exl
);

    logic        m1s_valid;
    es_to_m1_t   m1s_r;
    logic        req_sent;
    logic        data_done;
    logic        hold_r;
    logic        hold_int;
    logic [31:0] paddr;
    logic        adr_ex;
    logic [4:0]  adr_exccode;
    logic        int_pending;
    logic [31:0] cp0_rdata;
    logic        is_mem;
    logic        int_take;
    logic        m1s_ex;
    logic [4:0]  m1s_exccode;
    logic        m1s_ready;
    logic        fire;
    logic [31:0] m1s_result;

    assign is_mem = m1s_r.load_op || m1s_r.mem_we;

    // interrupt decision frozen while the output is held
    // no interrupt once the cache already has the access
    assign int_take = hold_r ? hold_int : (int_pending && !req_sent);

    // priority: interrupt, upstream exception, address error
    assign m1s_ex = int_take || m1s_r.ex || adr_ex;
    always_comb begin
        if (int_take) begin
            m1s_exccode = exc_int;
        end else if (m1s_r.ex) begin
            m1s_exccode = m1s_r.exccode;
        end else begin
            m1s_exccode = adr_exccode;
        end
    end

    // memory ops wait for data_ok, or for the remembered one
    assign m1s_ready = m1s_ex || !is_mem || data_done || (req_sent && data_data_ok);

    assign m1s_allowin     = !m1s_valid || (m1s_ready && ms_allowin);
    assign m1s_to_ms_valid = m1s_valid && m1s_ready;
    assign fire            = m1s_to_ms_valid && ms_allowin;

    // eret and exceptions redirect fetch on the way out
    assign flush = fire && (m1s_ex || m1s_r.inst_eret);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            m1s_valid <= 1'b0;
        end else if (m1s_allowin) begin
            m1s_valid <= es_to_m1s_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_to_m1s_valid && m1s_allowin) begin
            m1s_r <= es_to_m1s_bus;
        end
    end

    // request accepted, then data returned, both live until fire
    always_ff @(posedge clk) begin
        if (reset || fire) begin
            req_sent  <= 1'b0;
            data_done <= 1'b0;
        end else begin
            if (data_valid && data_addr_ok) begin
                req_sent <= 1'b1;
            end
            if (req_sent && data_data_ok) begin
                data_done <= 1'b1;
            end
        end
    end

    // memory-2 back-pressure on a ready word
    always_ff @(posedge clk) begin
        if (reset || fire) begin
            hold_r <= 1'b0;
        end else if (m1s_to_ms_valid && !ms_allowin && !hold_r) begin
            hold_r   <= 1'b1;
            hold_int <= int_take;
        end
    end

    data_addr_map u_data_addr_map (
        .vaddr       (m1s_r.alu_result),
        .mem_size    (m1s_r.mem_size),
        .load_op     (m1s_r.load_op),
        .mem_we      (m1s_r.mem_we),
        .paddr       (paddr),
        .uncached    (isUncache),
        .adr_ex      (adr_ex),
        .adr_exccode (adr_exccode)
    );

    // one request per access, faulting or eret words never reach the cache
    assign data_valid = m1s_valid && is_mem && !m1s_ex && !m1s_r.inst_eret && !req_sent;

    assign data_req.op     = m1s_r.mem_we;
    assign data_req.tag    = paddr[31:12];
    assign data_req.index  = paddr[11:4];
    assign data_req.offset = paddr[3:0];
    assign data_req.wstrb  = m1s_r.mem_wstrb;
    assign data_req.wdata  = m1s_r.mem_wdata;

    // side effects only on fire
    cp0_regs u_cp0_regs (
        .clk             (clk),
        .reset           (reset),
        .ext_int         (ext_int),
        .commit          (fire),
        .commit_ex       (m1s_ex),
        .commit_exccode  (m1s_exccode),
        .commit_pc       (m1s_r.pc),
        .commit_bd       (m1s_r.bd),
        // fetch faults report the pc itself
        .commit_badvaddr (m1s_r.ex ? m1s_r.pc : m1s_r.alu_result),
        .commit_mtc0     (m1s_r.inst_mtc0),
        .commit_eret     (m1s_r.inst_eret),
        .cp0_addr        (m1s_r.cp0_addr),
        .wdata           (m1s_r.alu_result),
        .rdata           (cp0_rdata),
        .int_pending     (int_pending),
        .epc             (exception_pc),
        .status_exl      (status_exl)
    );

    assign m1s_result = m1s_r.inst_mfc0 ? cp0_rdata : m1s_r.alu_result;

    assign m1s_to_ms_bus.pc       = m1s_r.pc;
    assign m1s_to_ms_bus.result   = m1s_result;
    assign m1s_to_ms_bus.dest     = m1s_r.dest;
    assign m1s_to_ms_bus.gr_we    = m1s_r.gr_we;
    assign m1s_to_ms_bus.load_op  = m1s_r.load_op;
    assign m1s_to_ms_bus.mem_size = m1s_r.mem_size;
    assign m1s_to_ms_bus.addr_low = m1s_r.alu_result[1:0];
    assign m1s_to_ms_bus.ex       = m1s_ex;

    // bypass to decode
    // load and mfc0 values are not final yet
    assign fwd_dest   = (m1s_valid && m1s_r.gr_we) ? m1s_r.dest : 5'd0;
    assign fwd_result = m1s_result;
    assign fwd_load   = m1s_valid && m1s_r.load_op;
    assign fwd_mfc0   = m1s_valid && m1s_r.inst_mfc0;

endmodule

// File: verilog/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs import m1_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [5:0]  ext_int,
    input  logic        commit,
    input  logic        commit_ex,
    input  logic [4:0]  commit_exccode,
    input  logic [31:0] commit_pc,
    input  logic        commit_bd,
    input  logic [31:0] commit_badvaddr,
    input  logic        commit_mtc0,
    input  logic        commit_eret,
    input  logic [4:0]  cp0_addr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic        int_pending,
    output logic [31:0] epc,
    output logic        status_exl
);

    logic [31:0] count;
    logic        count_tick;
    logic [31:0] compare;
    logic [7:0]  status_im;
    logic        status_ie;
    logic        cause_bd;
    logic        cause_ti;
    logic [5:0]  cause_ip_hw;
    logic [1:0]  cause_ip_sw;
    logic [4:0]  cause_exccode;
    logic [7:0]  cause_ip;
    logic [31:0] badvaddr;
    logic        exc_commit;
    logic        eret_commit;
    logic        mtc0_we;

    // an exception cancels the instruction's own eret or mtc0
    assign exc_commit  = commit && commit_ex;
    assign eret_commit = commit && commit_eret && !commit_ex;
    assign mtc0_we     = commit && commit_mtc0 && !commit_ex;

    // timer shares ip7 with hardware line 5
    assign cause_ip = {cause_ip_hw[5] | cause_ti, cause_ip_hw[4:0], cause_ip_sw};

    assign int_pending = status_ie && !status_exl && (|(cause_ip & status_im));

    // status: im, exl, ie
    always_ff @(posedge clk) begin
        if (reset) begin
            status_im  <= 8'd0;
            status_exl <= 1'b0;
            status_ie  <= 1'b0;
        end else if (exc_commit) begin
            status_exl <= 1'b1;
        end else if (eret_commit) begin
            status_exl <= 1'b0;
        end else if (mtc0_we && cp0_addr == cp0_status) begin
            status_im  <= wdata[15:8];
            status_exl <= wdata[1];
            status_ie  <= wdata[0];
        end
    end

    // cause: interrupt lines, timer flag, exception info
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd      <= 1'b0;
            cause_ti      <= 1'b0;
            cause_ip_hw   <= 6'd0;
            cause_ip_sw   <= 2'd0;
            cause_exccode <= 5'd0;
        end else begin
            // hardware lines sampled every cycle
            cause_ip_hw <= ext_int;
            if (exc_commit) begin
                cause_bd      <= commit_bd;
                cause_exccode <= commit_exccode;
            end else if (mtc0_we && cp0_addr == cp0_cause) begin
                // only the software interrupt bits are writable
                cause_ip_sw <= wdata[9:8];
            end
            // writing compare acknowledges the timer
            if (mtc0_we && cp0_addr == cp0_compare) begin
                cause_ti <= 1'b0;
            end else if (count == compare) begin
                cause_ti <= 1'b1;
            end
        end
    end

    // count runs at half the core clock
    always_ff @(posedge clk) begin
        if (reset) begin
            count      <= 32'd0;
            count_tick <= 1'b0;
        end else begin
            count_tick <= !count_tick;
            if (mtc0_we && cp0_addr == cp0_count) begin
                count <= wdata;
            end else if (count_tick) begin
                count <= count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mtc0_we && cp0_addr == cp0_compare) begin
            compare <= wdata;
        end
    end

    // epc keeps the first fault while exl is set
    always_ff @(posedge clk) begin
        if (exc_commit && !status_exl) begin
            // delay slot restarts at the branch
            epc <= commit_bd ? commit_pc - 32'd4 : commit_pc;
        end else if (mtc0_we && cp0_addr == cp0_epc) begin
            epc <= wdata;
        end
    end

    // faulting address for adel and ades
    always_ff @(posedge clk) begin
        if (exc_commit && (commit_exccode == exc_adel || commit_exccode == exc_ades)) begin
            badvaddr <= commit_badvaddr;
        end
    end

    // mfc0 read port
    always_comb begin
        case (cp0_addr)
            cp0_badvaddr: rdata = badvaddr;
            cp0_count:    rdata = count;
            cp0_compare:  rdata = compare;
            // bev is hardwired to 1
            cp0_status:   rdata = {9'd0, 1'b1, 6'd0, status_im, 6'd0, status_exl, status_ie};
            cp0_cause:    rdata = {cause_bd, cause_ti, 14'd0, cause_ip, 1'b0,
                                   cause_exccode, 2'b00};
            cp0_epc:      rdata = epc;
            default:      rdata = 32'd0;
        endcase
    end

endmodule

// File: verilog/data_addr_map.sv
`timescale 1ns/1ps

module data_addr_map import m1_pkg::*; (
    input  logic [31:0] vaddr,
    input  logic [1:0]  mem_size,
    input  logic        load_op,
    input  logic        mem_we,
    output logic [31:0] paddr,
    output logic        uncached,
    output logic        adr_ex,
    output logic [4:0]  adr_exccode
);

    logic [2:0] seg;
    logic       is_kseg0;
    logic       is_kseg1;
    logic       misaligned;

    // top three bits pick the segment
    assign seg      = vaddr[31:29];
    assign is_kseg0 = (seg == 3'b100);
    assign is_kseg1 = (seg == 3'b101);

    // unmapped segments drop the top bits
    // kuseg and kseg2/3 go through as is, no tlb here
    assign paddr = (is_kseg0 || is_kseg1) ? {3'b000, vaddr[28:0]} : vaddr;

    // only kseg1 bypasses the cache
    assign uncached = is_kseg1;

    always_comb begin
        case (mem_size)
            size_byte: misaligned = 1'b0;
            // halfword needs bit 0 clear
            size_half: misaligned = vaddr[0];
            // word needs both low bits clear
            size_word: misaligned = |vaddr[1:0];
            default:   misaligned = 1'b0;
        endcase
    end

    // only memory accesses can fault on alignment
    assign adr_ex = (load_op || mem_we) && misaligned;

    // store side takes ades, load side adel
    assign adr_exccode = mem_we ? exc_ades : exc_adel;

endmodule

// File: verilog/m1_pkg.sv
package m1_pkg;

    // mem_size encodings from execute
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    // cause.exccode values
    localparam logic [4:0] exc_int  = 5'd0;
    localparam logic [4:0] exc_adel = 5'd4;
    localparam logic [4:0] exc_ades = 5'd5;
    localparam logic [4:0] exc_sys  = 5'd8;
    localparam logic [4:0] exc_bp   = 5'd9;
    localparam logic [4:0] exc_ri   = 5'd10;
    localparam logic [4:0] exc_ov   = 5'd12;

    // cp0 register numbers, select 0 only
    localparam logic [4:0] cp0_badvaddr = 5'd8;
    localparam logic [4:0] cp0_count    = 5'd9;
    localparam logic [4:0] cp0_compare  = 5'd11;
    localparam logic [4:0] cp0_status   = 5'd12;
    localparam logic [4:0] cp0_cause    = 5'd13;
    localparam logic [4:0] cp0_epc      = 5'd14;

    // general exception entry with bev set
    // fetch side jumps here when flush comes with ex, and to exception_pc on eret
    localparam logic [31:0] exc_vector = 32'hbfc0_0380;

    // word handed over by execute
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_result;
        logic [4:0]  dest;
        logic        gr_we;
        logic        load_op;
        logic        mem_we;
        logic [1:0]  mem_size;
        // byte enables already shifted to the lane
        logic [3:0]  mem_wstrb;
        logic [31:0] mem_wdata;
        logic        inst_mfc0;
        logic        inst_mtc0;
        logic        inst_eret;
        logic [4:0]  cp0_addr;
        // instruction sits in a branch delay slot
        logic        bd;
        // exception raised upstream (fetch, decode, execute)
        logic        ex;
        logic [4:0]  exccode;
    } es_to_m1_t;

    // word passed on to memory-2
    typedef struct packed {
        logic [31:0] pc;
        // alu value, or cp0 read data for mfc0
        logic [31:0] result;
        logic [4:0]  dest;
        logic        gr_we;
        logic        load_op;
        logic [1:0]  mem_size;
        // for load data alignment in memory-2
        logic [1:0]  addr_low;
        logic        ex;
    } m1_to_ms_t;

    // data cache request, address split as tag/index/offset
    typedef struct packed {
        // 1 means write
        logic        op;
        logic [19:0] tag;
        logic [7:0]  index;
        logic [3:0]  offset;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } dcache_req_t;

endpackage
